// File: include/mhp_defines.svh
`ifndef MHP_DEFINES_SVH
`define MHP_DEFINES_SVH

// data path widths
`define MHP_BYTE_W          8
`define MHP_ADDR_W          8
`define MHP_NODE_W          16

// receive idle cycles that close a frame
`define MHP_RX_IDLE_LIMIT   63

// every transmitted frame has this many bytes
`define MHP_TX_FRAME_LEN    16
`define MHP_PACE_LOG2       10

// header layout and type codes (low five bits of the type byte)
`define MHP_TYPE_OFS        6
`define MHP_ACK_BIT         4
`define MHP_CMD_PING        5'd1
`define MHP_CMD_ADDR_REQ    5'd3
`define MHP_CMD_ADDR_GRANT  5'd4

`endif

// File: source/mhp_pkg.sv
`include "mhp_defines.svh"

package mhp_pkg;

  typedef logic [`MHP_BYTE_W-1:0] byte_t;
  typedef logic [`MHP_ADDR_W-1:0] ram_addr_t;
  typedef logic [`MHP_NODE_W-1:0] node_addr_t;
  typedef logic [4:0]             cmd_t;

  // one stage's access to the frame RAM, all zeros when idle
  typedef struct packed {
    logic      we;
    ram_addr_t addr;
    byte_t     wdata;
  } ram_req_t;

  typedef struct packed {
    node_addr_t src_addr;
    node_addr_t dst_addr;
    byte_t      msg_type;
  } msg_header_t;

  ////////////////////
  // FSM states

  typedef enum logic [2:0] {
    RX_IDLE, RX_ARMED, RX_POP, RX_LOAD, RX_WRITE, RX_GAP, RX_DONE
  } rx_state_e;

  typedef enum logic [2:0] {
    HDR_IDLE, HDR_ADDR, HDR_LOAD, HDR_NEXT, HDR_DONE
  } hdr_state_e;

  typedef enum logic [2:0] {
    BLD_IDLE, BLD_SET, BLD_WRITE, BLD_NEXT, BLD_DONE
  } bld_state_e;

  typedef enum logic [2:0] {
    TX_IDLE, TX_WAIT, TX_ADDR, TX_LOAD, TX_SEND, TX_DONE
  } tx_state_e;

  typedef enum logic [3:0] {
    CTRL_IDLE, CTRL_RX, CTRL_RX_WAIT, CTRL_HDR, CTRL_HDR_WAIT,
    CTRL_BLD, CTRL_BLD_WAIT, CTRL_TX, CTRL_TX_WAIT, CTRL_DONE
  } ctrl_state_e;

endpackage

// File: source/frame_ram.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module frame_ram
  import mhp_pkg::*;
(
  input  logic     i_clk,
  input  ram_req_t i_rx_req,
  input  ram_req_t i_hdr_req,
  input  ram_req_t i_bld_req,
  input  ram_req_t i_tx_req,
  output byte_t    o_rdata
);

  localparam int DEPTH = 2 ** `MHP_ADDR_W;

  byte_t    mem [DEPTH];
  ram_req_t req;

  // only one stage is active at a time, idle stages drive zeros
  always_comb begin
    req = i_rx_req | i_hdr_req | i_bld_req | i_tx_req;
  end

  // registered read, data one cycle after the address
  always_ff @(posedge i_clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
    o_rdata <= mem[req.addr];
  end

endmodule

// File: source/rx_frame_loader.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module rx_frame_loader
  import mhp_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_start,
  input  logic     i_rready,
  input  byte_t    i_rdata,
  output logic     o_rreq,
  output ram_req_t o_ram_req,
  output logic     o_rx_done
);

  localparam int IDLE_W = $clog2(`MHP_RX_IDLE_LIMIT + 1);

  rx_state_e         state;
  ram_addr_t         wr_addr;
  byte_t             wr_data;
  logic [IDLE_W-1:0] idle_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= RX_IDLE;
      wr_addr  <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          wr_addr <= '0;
          if (i_start) begin
            state <= RX_ARMED;
          end
        end
        // wait for the first byte, no timeout yet
        RX_ARMED: if (i_rready) state <= RX_POP;
        RX_POP:   state <= RX_LOAD;
        RX_LOAD:  state <= RX_WRITE;
        RX_WRITE: begin
          wr_addr  <= wr_addr + 1'b1;
          idle_cnt <= '0;
          state    <= i_rready ? RX_POP : RX_GAP;
        end
        RX_GAP: begin
          if (i_rready) begin
            state <= RX_POP;
          end else if (idle_cnt == IDLE_W'(`MHP_RX_IDLE_LIMIT - 1)) begin
            state <= RX_DONE;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // fifo data is valid the cycle after the pop
  always_ff @(posedge i_clk) begin
    if (state == RX_LOAD) begin
      wr_data <= i_rdata;
    end
  end

  assign o_rreq    = (state == RX_POP);
  assign o_rx_done = (state == RX_DONE);

  always_comb begin
    o_ram_req = '0;
    if (state == RX_WRITE) begin
      o_ram_req.we    = 1'b1;
      o_ram_req.addr  = wr_addr;
      o_ram_req.wdata = wr_data;
    end
  end

endmodule

// File: source/header_parser.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module header_parser
  import mhp_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  byte_t       i_rdata,
  output ram_req_t    o_ram_req,
  output msg_header_t o_header,
  output logic        o_done
);

  // src hi/lo, dst hi/lo, type
  localparam logic [2:0] LAST_IDX = 3'd4;

  hdr_state_e state;
  logic [2:0] idx;
  ram_addr_t  rd_addr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= HDR_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        HDR_IDLE: begin
          idx <= '0;
          if (i_start) state <= HDR_ADDR;
        end
        HDR_ADDR: state <= HDR_LOAD;
        HDR_LOAD: state <= HDR_NEXT;
        HDR_NEXT: begin
          idx   <= idx + 1'b1;
          state <= (idx == LAST_IDX) ? HDR_DONE : HDR_ADDR;
        end
        default: state <= HDR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == HDR_LOAD) begin
      case (idx)
        3'd0:    o_header.src_addr[15:8] <= i_rdata;
        3'd1:    o_header.src_addr[7:0]  <= i_rdata;
        3'd2:    o_header.dst_addr[15:8] <= i_rdata;
        3'd3:    o_header.dst_addr[7:0]  <= i_rdata;
        default: o_header.msg_type       <= i_rdata;
      endcase
    end
  end

  assign rd_addr = (idx == LAST_IDX) ? ram_addr_t'(`MHP_TYPE_OFS) : ram_addr_t'(idx);

  // read only, address driven during the address phase
  always_comb begin
    o_ram_req = '0;
    if (state == HDR_ADDR) begin
      o_ram_req.addr = rd_addr;
    end
  end

  assign o_done = (state == HDR_DONE);

endmodule

// File: source/reply_builder.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module reply_builder
  import mhp_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  msg_header_t i_header,
  output ram_req_t    o_ram_req,
  output ram_addr_t   o_reply_len,
  output logic        o_done
);

  bld_state_e state;
  cmd_t       cmd;
  cmd_t       cmd_q;
  logic       known;
  logic       swap_phase;
  ram_addr_t  idx;
  byte_t      cur_byte;

  ////////////////////
  // reply templates

  function automatic byte_t tpl_byte(cmd_t c, ram_addr_t i);
    logic  grant;
    byte_t b;
    grant = (c == `MHP_CMD_ADDR_GRANT);
    case (i)
      8'd0, 8'd1: b = 8'hff;
      8'd5:       b = grant ? 8'h02 : 8'h01;
      8'd6: begin
        case (c)
          `MHP_CMD_PING:     b = 8'h81;
          `MHP_CMD_ADDR_REQ: b = 8'h83;
          default:           b = 8'h92;
        endcase
      end
      8'd7:       b = grant ? 8'h01 : 8'h00;
      8'd8:       b = grant ? 8'h20 : 8'h00;
      default:    b = 8'h00;
    endcase
    return b;
  endfunction

  // ping is one byte shorter
  function automatic ram_addr_t tpl_len(cmd_t c);
    return (c == `MHP_CMD_PING) ? 8'd10 : 8'd11;
  endfunction

  assign cmd   = i_header.msg_type[4:0];
  assign known = !i_header.msg_type[`MHP_ACK_BIT] &&
                 (cmd == `MHP_CMD_PING || cmd == `MHP_CMD_ADDR_REQ ||
                  cmd == `MHP_CMD_ADDR_GRANT);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= BLD_IDLE;
      swap_phase  <= 1'b0;
      idx         <= '0;
      o_reply_len <= '0;
    end else begin
      case (state)
        BLD_IDLE: begin
          if (i_start) begin
            idx        <= '0;
            swap_phase <= 1'b0;
            cmd_q      <= cmd;
            // ack or unknown type, nothing to send
            o_reply_len <= known ? tpl_len(cmd) : '0;
            state       <= known ? BLD_SET : BLD_DONE;
          end
        end
        BLD_SET:   state <= BLD_WRITE;
        BLD_WRITE: state <= BLD_NEXT;
        BLD_NEXT: begin
          state <= BLD_SET;
          if (swap_phase) begin
            idx <= idx + 1'b1;
            if (idx == 8'd3) state <= BLD_DONE;
          end else if (idx == o_reply_len - 1'b1) begin
            swap_phase <= 1'b1;
            idx        <= '0;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: state <= BLD_IDLE;
      endcase
    end
  end

  // swapped addresses go to bytes 0-3, high byte first
  always_comb begin
    case (idx[1:0])
      2'd0:    cur_byte = i_header.dst_addr[15:8];
      2'd1:    cur_byte = i_header.dst_addr[7:0];
      2'd2:    cur_byte = i_header.src_addr[15:8];
      default: cur_byte = i_header.src_addr[7:0];
    endcase
    if (!swap_phase) begin
      cur_byte = tpl_byte(cmd_q, idx);
    end
  end

  always_comb begin
    o_ram_req = '0;
    if (state == BLD_SET || state == BLD_WRITE) begin
      o_ram_req.we    = (state == BLD_WRITE);
      o_ram_req.addr  = idx;
      o_ram_req.wdata = cur_byte;
    end
  end

  assign o_done = (state == BLD_DONE);

endmodule

// File: source/tx_frame_sender.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module tx_frame_sender
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_start,
  input  ram_addr_t i_reply_len,
  input  logic      i_wready,
  input  byte_t     i_rdata,
  output ram_req_t  o_ram_req,
  output byte_t     o_wdata,
  output logic      o_wvalid,
  output logic      o_done
);

  localparam ram_addr_t LAST_IDX = ram_addr_t'(`MHP_TX_FRAME_LEN - 1);

  tx_state_e                 state;
  ram_addr_t                 idx;
  logic [`MHP_PACE_LOG2-1:0] pace_cnt;
  logic                      pace_stb;

  // free-running pacing counter
  always_ff @(posedge i_clk) begin
    if (i_rst) pace_cnt <= '0;
    else       pace_cnt <= pace_cnt + 1'b1;
  end

  assign pace_stb = &pace_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= TX_IDLE;
      idx     <= '0;
      o_wdata <= '0;
    end else begin
      case (state)
        TX_IDLE: if (i_start) state <= TX_WAIT;
        // back-pressure only holds off the start
        TX_WAIT: begin
          idx <= '0;
          if (pace_stb && i_wready) state <= TX_ADDR;
        end
        TX_ADDR: state <= TX_LOAD;
        TX_LOAD: begin
          // zero padding past the reply
          o_wdata <= (idx < i_reply_len) ? i_rdata : '0;
          state   <= TX_SEND;
        end
        TX_SEND: begin
          idx   <= idx + 1'b1;
          state <= (idx == LAST_IDX) ? TX_DONE : TX_ADDR;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_comb begin
    o_ram_req = '0;
    if (state == TX_ADDR) o_ram_req.addr = idx;
  end

  assign o_wvalid = (state == TX_SEND);
  assign o_done   = (state == TX_DONE);

endmodule

// File: source/mhp_ctrl.sv
`timescale 1ns/1ps

module mhp_ctrl
  import mhp_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_rx_done,
  input  logic      i_hdr_done,
  input  logic      i_bld_done,
  input  ram_addr_t i_reply_len,
  input  logic      i_tx_done,
  output logic      o_rx_start,
  output logic      o_hdr_start,
  output logic      o_bld_start,
  output logic      o_tx_start,
  output logic      o_done
);

  ctrl_state_e state;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= CTRL_IDLE;
    end else begin
      case (state)
        CTRL_IDLE:     state <= CTRL_RX;
        CTRL_RX:       state <= CTRL_RX_WAIT;
        CTRL_RX_WAIT:  if (i_rx_done) state <= CTRL_HDR;
        CTRL_HDR:      state <= CTRL_HDR_WAIT;
        CTRL_HDR_WAIT: if (i_hdr_done) state <= CTRL_BLD;
        CTRL_BLD:      state <= CTRL_BLD_WAIT;
        CTRL_BLD_WAIT: begin
          // empty reply means no transmit
          if (i_bld_done) begin
            state <= (i_reply_len == '0) ? CTRL_DONE : CTRL_TX;
          end
        end
        CTRL_TX:       state <= CTRL_TX_WAIT;
        CTRL_TX_WAIT:  if (i_tx_done) state <= CTRL_DONE;
        // receive is re-armed only after done
        CTRL_DONE:     state <= CTRL_RX;
        default:       state <= CTRL_IDLE;
      endcase
    end
  end

  // one-cycle start pulses
  assign o_rx_start  = (state == CTRL_RX);
  assign o_hdr_start = (state == CTRL_HDR);
  assign o_bld_start = (state == CTRL_BLD);
  assign o_tx_start  = (state == CTRL_TX);
  assign o_done      = (state == CTRL_DONE);

endmodule

// File: source/mhp_top.sv
`timescale 1ns/1ps

module mhp_top
  import mhp_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_rready,
  input  byte_t i_rdata,
  output logic  o_rreq,
  input  logic  i_wready,
  output byte_t o_wdata,
  output logic  o_wvalid,
  output logic  o_done
);

  ram_req_t    rx_req;
  ram_req_t    hdr_req;
  ram_req_t    bld_req;
  ram_req_t    tx_req;
  byte_t       ram_rdata;
  msg_header_t header;
  ram_addr_t   reply_len;
  logic        rx_start;
  logic        rx_done;
  logic        hdr_start;
  logic        hdr_done;
  logic        bld_start;
  logic        bld_done;
  logic        tx_start;
  logic        tx_done;

  ////////////////////
  // sequencer

  mhp_ctrl u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rx_done(rx_done), .i_hdr_done(hdr_done), .i_bld_done(bld_done),
    .i_reply_len(reply_len), .i_tx_done(tx_done),
    .o_rx_start(rx_start), .o_hdr_start(hdr_start),
    .o_bld_start(bld_start), .o_tx_start(tx_start), .o_done(o_done)
  );

  ////////////////////
  // stages and shared RAM

  frame_ram u_ram (
    .i_clk(i_clk), .i_rx_req(rx_req), .i_hdr_req(hdr_req),
    .i_bld_req(bld_req), .i_tx_req(tx_req), .o_rdata(ram_rdata)
  );

  rx_frame_loader u_rx (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(rx_start),
    .i_rready(i_rready), .i_rdata(i_rdata), .o_rreq(o_rreq),
    .o_ram_req(rx_req), .o_rx_done(rx_done)
  );

  header_parser u_hdr (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(hdr_start), .i_rdata(ram_rdata),
    .o_ram_req(hdr_req), .o_header(header), .o_done(hdr_done)
  );

  reply_builder u_bld (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(bld_start), .i_header(header),
    .o_ram_req(bld_req), .o_reply_len(reply_len), .o_done(bld_done)
  );

  tx_frame_sender u_tx (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(tx_start), .i_reply_len(reply_len),
    .i_wready(i_wready), .i_rdata(ram_rdata), .o_ram_req(tx_req),
    .o_wdata(o_wdata), .o_wvalid(o_wvalid), .o_done(tx_done)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RST_CYCLES     = 16
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  // reset drops on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

// File: dv/tb_mhp.sv
`timescale 1ns/1ps
`include "mhp_defines.svh"

module tb_mhp
  import mhp_pkg::*;
();

  localparam int MAX_TESTS       = 16;
  localparam int MAX_IN          = 32;
  localparam int FRAME_LEN       = `MHP_TX_FRAME_LEN;
  localparam int CYCLES_PER_TEST = 3000;

  logic  i_clk;
  logic  i_rst;
  logic  i_rready;
  byte_t i_rdata;
  logic  o_rreq;
  logic  i_wready;
  byte_t o_wdata;
  logic  o_wvalid;
  logic  o_done;

  // test records from the stimulus file
  string names [MAX_TESTS];
  byte_t in_data [MAX_TESTS][MAX_IN];
  int    in_len [MAX_TESTS];
  bit    ovl [MAX_TESTS];
  int    wlow [MAX_TESTS];
  bit    has_reply [MAX_TESTS];
  byte_t exp_data [MAX_TESTS][FRAME_LEN];
  int    n_tests;

  byte_t fifo_q [$];
  byte_t got_q [$];
  int    got_cnt     = 0;
  int    done_cnt    = 0;
  int    wready_hold = 0;
  bit    hold_rx     = 1'b0;
  bit    pushed_early = 1'b0;
  int    errors      = 0;
  int    checks      = 0;
  int    cycles      = 0;
  int    cycle_limit = 1000000;
  bit    stim_ok;

  tb_clk_gen u_clk (.o_clk(i_clk), .o_rst(i_rst));

  mhp_top DUT (
    .i_clk(i_clk), .i_rst(i_rst), .i_rready(i_rready), .i_rdata(i_rdata),
    .o_rreq(o_rreq), .i_wready(i_wready), .o_wdata(o_wdata),
    .o_wvalid(o_wvalid), .o_done(o_done)
  );

  ////////////////////
  // bus models, all on the falling edge

  always @(negedge i_clk) begin
    // sample outputs first, then drive the next inputs
    if (o_wvalid) begin
      if (!i_wready) begin
        errors++;
        $display("o_wvalid went high while i_wready was held low");
      end
      got_q.push_back(o_wdata);
      got_cnt++;
    end
    if (o_rreq && hold_rx) begin
      errors++;
      $display("a byte was popped before the previous frame was done");
    end
    if (o_done) begin
      done_cnt++;
      hold_rx = 1'b0;
    end
    // receive FIFO, data valid in the cycle after the pop
    if (o_rreq) begin
      if (fifo_q.size() == 0) begin
        errors++;
        $display("the DUT popped an empty receive FIFO");
      end else begin
        i_rdata = fifo_q.pop_front();
      end
    end
    i_rready = (fifo_q.size() != 0);
    if (wready_hold > 0) begin
      i_wready = 1'b0;
      wready_hold--;
    end else begin
      i_wready = 1'b1;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never finished", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // helpers

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", what, exp, act);
    end
  endtask

  task automatic read_stim(output bit ok);
    int    fd;
    int    code;
    int    i;
    int    v;
    int    v_len;
    string tok;
    string line;
    ok = 1'b0;
    n_tests = 0;
    fd = $fopen("dv/mhp_stim.txt", "r");
    if (fd != 0) begin
      while (n_tests < MAX_TESTS) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
          continue;
        end
        names[n_tests] = tok;
        code = $fscanf(fd, "%d %d %d", ovl[n_tests], wlow[n_tests], v_len);
        in_len[n_tests] = (v_len > MAX_IN) ? MAX_IN : v_len;
        for (i = 0; i < in_len[n_tests]; i++) begin
          code = $fscanf(fd, "%h", v);
          in_data[n_tests][i] = byte_t'(v);
        end
        code = $fscanf(fd, "%s", tok);
        has_reply[n_tests] = (tok != "none");
        if (has_reply[n_tests]) begin
          code = $sscanf(tok, "%h", v);
          exp_data[n_tests][0] = byte_t'(v);
          for (i = 1; i < FRAME_LEN; i++) begin
            code = $fscanf(fd, "%h", v);
            exp_data[n_tests][i] = byte_t'(v);
          end
        end
        n_tests++;
      end
      $fclose(fd);
      ok = (n_tests > 0);
    end
  endtask

  // called right after a rising edge
  task automatic push_frame(input int t);
    int i;
    for (i = 0; i < in_len[t]; i++) begin
      fifo_q.push_back(in_data[t][i]);
    end
  endtask

  task automatic check_quiet();
    int i;
    int err_base;
    err_base = errors;
    for (i = 0; i < 8; i++) begin
      @(negedge i_clk);
      check("reset o_rreq", 0, o_rreq);
      check("reset o_wvalid", 0, o_wvalid);
      check("reset o_done", 0, o_done);
      check("reset o_wdata", 0, o_wdata);
    end
    $display("reset: %s", (errors == err_base) ? "ok" : "mismatch");
  endtask

  task automatic run_test(input int t);
    int i;
    int err_base;
    int done_base;
    err_base  = errors;
    done_base = done_cnt;
    @(posedge i_clk);
    got_q.delete();
    got_cnt     = 0;
    wready_hold = wlow[t];
    if (!pushed_early) push_frame(t);
    pushed_early = 1'b0;
    // next frame arrives while this reply is going out
    if (ovl[t] && (t + 1 < n_tests)) begin
      wait (got_cnt != 0);
      @(posedge i_clk);
      push_frame(t + 1);
      hold_rx      = 1'b1;
      pushed_early = 1'b1;
    end
    wait (done_cnt != done_base);
    if (has_reply[t]) begin
      check({names[t], " byte count"}, FRAME_LEN, got_q.size());
      for (i = 0; i < FRAME_LEN && i < got_q.size(); i++) begin
        check($sformatf("%s byte %0d", names[t], i), exp_data[t][i], got_q[i]);
      end
    end else begin
      check({names[t], " byte count"}, 0, got_q.size());
    end
    $display("%s: %s", names[t], (errors == err_base) ? "ok" : "mismatch");
  endtask

  ////////////////////
  // main sequence

  initial begin
    int t;
    i_rready = 1'b0;
    i_rdata  = '0;
    i_wready = 1'b1;
    read_stim(stim_ok);
    if (!stim_ok) begin
      $display("stimulus file dv/mhp_stim.txt could not be read");
      $display("Checks failed");
      $finish;
    end else begin
      cycle_limit = n_tests * CYCLES_PER_TEST;
      wait (i_rst == 1'b0);
      check_quiet();
      for (t = 0; t < n_tests; t++) begin
        run_test(t);
      end
      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
      if (errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// File: dv/mhp_stim.txt
# name overlap wready_low_cycles in_count in_bytes(hex)
# then 16 expected output bytes (hex) or none
ping 0 0 8 12 34 56 78 00 00 01 aa
56 78 12 34 00 01 81 00 00 00 00 00 00 00 00 00
addr_grant 0 0 8 a1 b2 c3 d4 00 00 04 00
c3 d4 a1 b2 00 02 92 01 20 00 00 00 00 00 00 00
addr_req 0 0 7 0f 0e 0d 0c 11 22 03
0d 0c 0f 0e 00 01 83 00 00 00 00 00 00 00 00 00
# ack bit set, no reply expected
ack 0 0 7 01 02 03 04 00 00 11
none
unknown_type 0 0 7 05 06 07 08 00 00 07
none
# wready low for 1500 cycles from the push
backpressure 0 1500 7 44 55 66 77 00 00 01
66 77 44 55 00 01 81 00 00 00 00 00 00 00 00 00
# second frame is pushed while the first reply goes out
b2b_first 1 0 7 10 20 30 40 00 00 04
30 40 10 20 00 02 92 01 20 00 00 00 00 00 00 00
b2b_second 0 0 7 88 99 aa bb 00 00 03
aa bb 88 99 00 01 83 00 00 00 00 00 00 00 00 00

// File: tb.f
+incdir+include
source/mhp_pkg.sv
source/frame_ram.sv
source/rx_frame_loader.sv
source/header_parser.sv
source/reply_builder.sv
source/tx_frame_sender.sv
source/mhp_ctrl.sv
source/mhp_top.sv
dv/tb_clk_gen.sv
dv/tb_mhp.sv

// File: Bender.yml
package:
  name: mhp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mhp_pkg.sv
      - source/frame_ram.sv
      - source/rx_frame_loader.sv
      - source/header_parser.sv
      - source/reply_builder.sv
      - source/tx_frame_sender.sv
      - source/mhp_ctrl.sv
      - source/mhp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mhp.sv
